// ==== rtl/encap_pkg.sv ====
package encap_pkg;

   // toy code dimensions
   localparam int N_BITS    = 128;
   localparam int SYND_BITS = 32;
   localparam int N_COLS    = N_BITS - SYND_BITS;

   // stream lengths in 32-bit words
   localparam int E_WORDS   = 4;
   localparam int MSG_WORDS = 6;
   localparam int K_WORDS   = 8;

   // SHAKE256 with 256 output bits requested
   localparam logic [31:0] SHAKE_FIRST_IN = 32'h4000_0100;
   // last block flag with 168 bits in the block
   localparam logic [31:0] SHAKE_LAST_IN  = 32'h8000_00A8;

   localparam logic [7:0] DOMAIN_K = 8'h01;

   typedef logic [31:0] word_t;

   typedef logic [6:0] pk_addr_t;

   // public-key column read
   typedef struct packed {
      logic     rd;
      pk_addr_t addr;
   } pk_req_t;

   typedef logic [2:0] k_addr_t;

   // session key read
   typedef struct packed {
      logic    rd;
      k_addr_t addr;
   } key_rd_t;

   // input of the K hash before framing
   typedef struct packed {
      logic [N_BITS-1:0] e;
      word_t             c0;
   } hash_msg_t;

endpackage

// ==== rtl/stream_slice.sv ====
`timescale 1ns/1ps

module stream_slice #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   logic load;

   // empty or draining this cycle
   assign in_ready = ~out_valid | out_ready;
   assign load     = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // data only moves on a transfer, so it holds while stalled
   always_ff @(posedge clk) begin
      if (load) begin
         out_data <= in_data;
      end
   end

endmodule

// ==== rtl/error_store.sv ====
`timescale 1ns/1ps

module error_store (
   input  logic                         clk,
   input  logic                         rst,
   input  encap_pkg::word_t             e_in,
   input  logic                         e_in_valid,
   output logic                         e_in_ready,
   input  logic                         e_release,
   output logic [encap_pkg::N_BITS-1:0] error_vec,
   output logic                         e_full
);

   logic [$clog2(encap_pkg::E_WORDS)-1:0] word_cnt;
   logic                                   take;
   logic                                   last_word;

   // closed for the whole run
   assign e_in_ready = ~e_full;
   assign take       = e_in_valid & e_in_ready;
   assign last_word  = (word_cnt == encap_pkg::E_WORDS - 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         word_cnt <= '0;
         e_full   <= 1'b0;
      end else if (e_release) begin
         word_cnt <= '0;
         e_full   <= 1'b0;
      end else if (take) begin
         word_cnt <= word_cnt + 1'b1;
         if (last_word) begin
            e_full <= 1'b1;
         end
      end
   end

   // low word first, so shift in from the top
   always_ff @(posedge clk) begin
      if (take) begin
         error_vec <= {e_in, error_vec[encap_pkg::N_BITS-1:$bits(encap_pkg::word_t)]};
      end
   end

endmodule

// ==== rtl/syndrome_encoder.sv ====
`timescale 1ns/1ps

module syndrome_encoder (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         e_full,
   input  logic [encap_pkg::N_BITS-1:0] error_vec,
   output encap_pkg::pk_req_t           pk_req,
   input  encap_pkg::word_t             pk_col,
   output encap_pkg::word_t             c0,
   output logic                         c0_valid
);

   encap_pkg::pk_req_t   req_q;
   encap_pkg::pk_addr_t  col_idx;
   encap_pkg::word_t     acc;
   encap_pkg::word_t     acc_next;
   logic                 e_full_q;
   logic                 start;
   logic                 col_vld;
   logic                 last_col;
   logic                 last_req;

   assign pk_req = req_q;

   // one run per rising edge of e_full
   assign start    = e_full & ~e_full_q;
   assign last_req = (req_q.addr == encap_pkg::N_COLS - 1);
   assign last_col = col_vld & (col_idx == encap_pkg::N_COLS - 1);

   // column j belongs to e bit 32+j
   assign acc_next = error_vec[encap_pkg::SYND_BITS + col_idx] ? (acc ^ pk_col) : acc;

   always_ff @(posedge clk) begin
      if (rst) begin
         e_full_q <= 1'b0;
         req_q    <= '0;
         col_vld  <= 1'b0;
         c0_valid <= 1'b0;
      end else begin
         e_full_q <= e_full;
         col_vld  <= req_q.rd;
         c0_valid <= last_col;
         if (start) begin
            req_q.rd   <= 1'b1;
            req_q.addr <= '0;
         end else if (req_q.rd) begin
            if (last_req) begin
               req_q.rd <= 1'b0;
            end else begin
               req_q.addr <= req_q.addr + 1'b1;
            end
         end
      end
   end

   // column index follows the memory by one cycle
   always_ff @(posedge clk) begin
      col_idx <= req_q.addr;
   end

   // identity part seeds the accumulator
   always_ff @(posedge clk) begin
      if (start) begin
         acc <= error_vec[encap_pkg::SYND_BITS-1:0];
      end else if (col_vld) begin
         acc <= acc_next;
      end
   end

   always_ff @(posedge clk) begin
      if (last_col) begin
         c0 <= acc_next;
      end
   end

endmodule

// ==== rtl/hash_framer.sv ====
`timescale 1ns/1ps

module hash_framer (
   input  logic                 clk,
   input  logic                 rst,
   input  encap_pkg::hash_msg_t msg,
   input  logic                 msg_valid,
   output encap_pkg::word_t     shake_in,
   output logic                 shake_in_valid,
   input  logic                 shake_in_ready,
   output logic                 framed
);

   encap_pkg::hash_msg_t                         msg_q;
   encap_pkg::word_t                             word;
   logic [encap_pkg::MSG_WORDS*32-1:0]           msg_bytes;
   logic [$clog2(encap_pkg::MSG_WORDS+2)-1:0]    word_cnt;
   logic [$clog2(encap_pkg::MSG_WORDS+2)-1:0]    data_idx;
   logic                                         active;
   logic                                         slice_ready;
   logic                                         fire;
   logic                                         last_word;

   // domain byte first, so e and c0 land one byte up
   assign msg_bytes = {
      {(encap_pkg::MSG_WORDS*32 - 8 - $bits(encap_pkg::hash_msg_t)){1'b0}},
      msg_q.c0,
      msg_q.e,
      encap_pkg::DOMAIN_K
   };

   // two header words ahead of the data
   assign data_idx  = word_cnt - 2'd2;
   assign fire      = active & slice_ready;
   assign last_word = (word_cnt == encap_pkg::MSG_WORDS + 1);

   always_comb begin
      case (word_cnt)
         'd0:     word = encap_pkg::SHAKE_FIRST_IN;
         'd1:     word = encap_pkg::SHAKE_LAST_IN;
         default: word = msg_bytes[32*data_idx +: 32];
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active   <= 1'b0;
         word_cnt <= '0;
         framed   <= 1'b0;
      end else begin
         framed <= fire & last_word;
         if (msg_valid) begin
            active   <= 1'b1;
            word_cnt <= '0;
         end else if (fire) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
               active <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (msg_valid) begin
         msg_q <= msg;
      end
   end

   stream_slice #(
      .payload_t (encap_pkg::word_t)
   ) u_slice (
      .clk       (clk),
      .rst       (rst),
      .in_data   (word),
      .in_valid  (active),
      .in_ready  (slice_ready),
      .out_data  (shake_in),
      .out_valid (shake_in_valid),
      .out_ready (shake_in_ready)
   );

endmodule

// ==== rtl/key_store.sv ====
`timescale 1ns/1ps

module key_store (
   input  logic               clk,
   input  logic               rst,
   input  logic               framed,
   input  encap_pkg::word_t   shake_out,
   input  logic               shake_out_valid,
   output logic               shake_out_ready,
   input  encap_pkg::key_rd_t key_rd,
   output encap_pkg::word_t   k_out,
   output logic               done,
   output logic               e_release
);

   encap_pkg::word_t   key_mem [encap_pkg::K_WORDS];
   encap_pkg::k_addr_t wr_ptr;
   logic               capture;
   logic               last_word;

   assign capture   = shake_out_ready & shake_out_valid;
   assign last_word = (wr_ptr == encap_pkg::K_WORDS - 1);
   // error vector is free again once K is in
   assign e_release = done;

   always_ff @(posedge clk) begin
      if (rst) begin
         shake_out_ready <= 1'b0;
         wr_ptr          <= '0;
         done            <= 1'b0;
      end else begin
         done <= capture & last_word;
         if (framed) begin
            shake_out_ready <= 1'b1;
            wr_ptr          <= '0;
         end else if (capture) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (last_word) begin
               shake_out_ready <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         key_mem[wr_ptr] <= shake_out;
      end
      if (key_rd.rd) begin
         k_out <= key_mem[key_rd.addr];
      end
   end

endmodule

// ==== rtl/encap_top.sv ====
`timescale 1ns/1ps

module encap_top (
   input  logic               clk,
   input  logic               rst,
   // error vector in
   input  encap_pkg::word_t   e_in,
   input  logic               e_in_valid,
   output logic               e_in_ready,
   // public-key memory
   output encap_pkg::pk_req_t pk_req,
   input  encap_pkg::word_t   pk_col,
   // SHAKE core
   output encap_pkg::word_t   shake_in,
   output logic               shake_in_valid,
   input  logic               shake_in_ready,
   input  encap_pkg::word_t   shake_out,
   input  logic               shake_out_valid,
   output logic               shake_out_ready,
   // results
   output encap_pkg::word_t   c0,
   input  encap_pkg::key_rd_t key_rd,
   output encap_pkg::word_t   k_out,
   output logic               done
);

   logic [encap_pkg::N_BITS-1:0] error_vec;
   logic                         e_full;
   logic                         e_release;
   logic                         c0_valid;
   logic                         framed;
   encap_pkg::hash_msg_t         msg;

   assign msg.e  = error_vec;
   assign msg.c0 = c0;

   error_store u_error_store (
      .clk        (clk),
      .rst        (rst),
      .e_in       (e_in),
      .e_in_valid (e_in_valid),
      .e_in_ready (e_in_ready),
      .e_release  (e_release),
      .error_vec  (error_vec),
      .e_full     (e_full)
   );

   syndrome_encoder u_syndrome_encoder (
      .clk       (clk),
      .rst       (rst),
      .e_full    (e_full),
      .error_vec (error_vec),
      .pk_req    (pk_req),
      .pk_col    (pk_col),
      .c0        (c0),
      .c0_valid  (c0_valid)
   );

   hash_framer u_hash_framer (
      .clk            (clk),
      .rst            (rst),
      .msg            (msg),
      .msg_valid      (c0_valid),
      .shake_in       (shake_in),
      .shake_in_valid (shake_in_valid),
      .shake_in_ready (shake_in_ready),
      .framed         (framed)
   );

   key_store u_key_store (
      .clk             (clk),
      .rst             (rst),
      .framed          (framed),
      .shake_out       (shake_out),
      .shake_out_valid (shake_out_valid),
      .shake_out_ready (shake_out_ready),
      .key_rd          (key_rd),
      .k_out           (k_out),
      .done            (done),
      .e_release       (e_release)
   );

endmodule

// ==== sim/encap_checker.sv ====
`timescale 1ns/1ps

module encap_checker (
   input logic             clk,
   input logic             rst,
   input encap_pkg::word_t shake_in,
   input logic             shake_in_valid,
   input logic             shake_in_ready,
   input logic             e_in_valid,
   input logic             e_in_ready,
   input logic             done
);

   logic [2:0] n_words;
   int         fail_cnt = 0;

   // error words taken in the current run
   always_ff @(posedge clk) begin
      if (rst || done) begin
         n_words <= '0;
      end else if (e_in_valid && e_in_ready) begin
         n_words <= n_words + 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      shake_in_valid && !shake_in_ready |=> shake_in_valid && $stable(shake_in))
   else begin
      $error("shake_in changed while stalled");
      fail_cnt++;
   end

   assert property (@(posedge clk) disable iff (rst) done |=> !done)
   else begin
      $error("done longer than one cycle");
      fail_cnt++;
   end

   // closed from the fourth word until done
   assert property (@(posedge clk) disable iff (rst) n_words == 3'd4 |-> !e_in_ready)
   else begin
      $error("e_in_ready high during a run");
      fail_cnt++;
   end

   assert property (@(posedge clk) disable iff (rst) $rose(e_in_ready) |-> $past(done))
   else begin
      $error("e_in_ready rose without done");
      fail_cnt++;
   end

endmodule

bind encap_top encap_checker u_checker (
   .clk            (clk),
   .rst            (rst),
   .shake_in       (shake_in),
   .shake_in_valid (shake_in_valid),
   .shake_in_ready (shake_in_ready),
   .e_in_valid     (e_in_valid),
   .e_in_ready     (e_in_ready),
   .done           (done)
);

// ==== sim/encap_tb.sv ====
`timescale 1ns/1ps

module encap_tb;

   logic                clk = 1'b0;
   logic                rst;
   encap_pkg::word_t    e_in;
   logic                e_in_valid;
   logic                e_in_ready;
   encap_pkg::pk_req_t  pk_req;
   encap_pkg::word_t    pk_col = '0;
   encap_pkg::word_t    shake_in;
   logic                shake_in_valid;
   logic                shake_in_ready = 1'b0;
   encap_pkg::word_t    shake_out = '0;
   logic                shake_out_valid = 1'b0;
   logic                shake_out_ready;
   encap_pkg::word_t    c0;
   encap_pkg::key_rd_t  key_rd;
   encap_pkg::word_t    k_out;
   logic                done;

   // six words per line
   encap_pkg::word_t    tdata [48];
   encap_pkg::word_t    pk_mem [96];
   encap_pkg::pk_addr_t rd_addr = '0;
   logic                rd_q = 1'b0;
   logic [31:0]         rng = 32'd79;
   logic                out_taken = 1'b0;
   encap_pkg::word_t    in_words [$];
   encap_pkg::word_t    out_words [$];
   int                  errors = 0;
   int                  n_run = 0;
   int                  n_pass = 0;
   int                  timeout_cycles = 2000;
   logic                timed_out = 1'b0;

   encap_top u_dut (.*);

   initial begin
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // SHAKE input word idx for error vector e and syndrome c
   function automatic logic [31:0] expected_frame_word(input int idx, input logic [127:0] e,
                                                       input logic [31:0] c);
      logic [7:0] msg [24];
      int         i;
      if (idx == 0)
         return 32'h4000_0100;
      if (idx == 1)
         return 32'h8000_00a8;
      msg[0] = 8'h01;
      for (i = 0; i < 16; i++)
         msg[1+i] = e[8*i +: 8];
      for (i = 0; i < 4; i++)
         msg[17+i] = c[8*i +: 8];
      for (i = 21; i < 24; i++)
         msg[i] = 8'h00;
      i = 4 * (idx - 2);
      return {msg[i+3], msg[i+2], msg[i+1], msg[i]};
   endfunction

   // public-key memory with one cycle of latency
   always @(posedge clk) begin
      rd_q    <= pk_req.rd;
      rd_addr <= pk_req.addr;
   end

   always @(negedge clk) begin
      pk_col <= (rd_q === 1'b1) ? pk_mem[rd_addr] : '0;
   end

   // SHAKE core stub
   always @(posedge clk) begin
      if (shake_in_valid && shake_in_ready)
         in_words.push_back(shake_in);
      out_taken <= shake_out_valid && shake_out_ready;
   end

   always @(negedge clk) begin
      rng = xorshift(rng);
      shake_in_ready <= (rng[1:0] != 2'b00);
      if (!shake_out_valid || out_taken) begin
         if (in_words.size() == 8 && out_words.size() < 8 && rng[3:2] != 2'b00) begin
            rng = xorshift(rng);
            shake_out       <= rng;
            shake_out_valid <= 1'b1;
            out_words.push_back(rng);
         end else begin
            shake_out_valid <= 1'b0;
         end
      end
   end

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      n_run++;
      if (errors == err_start) begin
         n_pass++;
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err_start);
      end
   endtask

   task automatic check_reset();
      int err_start;
      err_start = errors;
      check_word("done", done, 0);
      check_word("pk_req.rd", pk_req.rd, 0);
      check_word("shake_in_valid", shake_in_valid, 0);
      check_word("shake_out_ready", shake_out_ready, 0);
      check_word("e_in_ready", e_in_ready, 1);
      report_test("reset", err_start);
   endtask

   task automatic send_error_word(input encap_pkg::word_t w);
      int cyc;
      cyc        = 0;
      e_in       = w;
      e_in_valid = 1'b1;
      while (e_in_ready !== 1'b1 && cyc < timeout_cycles) begin
         @(negedge clk);
         cyc++;
      end
      assert (e_in_ready === 1'b1) else begin
         $display("timed out waiting for e_in_ready");
         timed_out = 1'b1;
         errors++;
      end
      // taken at the rising edge in between
      if (!timed_out)
         @(negedge clk);
   endtask

   task automatic run_test(input int t);
      logic [127:0]     e;
      logic [31:0]      x;
      encap_pkg::word_t exp_c0;
      int               j;
      int               cyc;
      int               err_start;
      err_start = errors;
      e         = {tdata[6*t+3], tdata[6*t+2], tdata[6*t+1], tdata[6*t]};
      exp_c0    = tdata[6*t+5];
      x         = tdata[6*t+4];
      for (j = 0; j < 96; j++) begin
         x         = xorshift(x);
         pk_mem[j] = x;
      end
      out_words.delete();
      in_words.delete();
      for (j = 0; j < 4; j++) begin
         if (!timed_out)
            send_error_word(e[32*j +: 32]);
      end
      e_in_valid = 1'b0;
      cyc = 0;
      while (!timed_out && done !== 1'b1 && cyc < timeout_cycles) begin
         check_word("e_in_ready", e_in_ready, 0);
         @(negedge clk);
         cyc++;
      end
      assert (timed_out || done === 1'b1) else begin
         $display("test %0d timed out waiting for done", t);
         timed_out = 1'b1;
         errors++;
      end
      if (!timed_out) begin
         check_word("c0", c0, exp_c0);
         @(negedge clk);
         check_word("e_in_ready", e_in_ready, 1);
         check_word("shake_in word count", in_words.size(), 8);
         for (j = 0; j < in_words.size() && j < 8; j++)
            check_word($sformatf("shake_in[%0d]", j), in_words[j],
                       expected_frame_word(j, e, exp_c0));
         check_word("shake_out word count", out_words.size(), 8);
         for (j = 0; j < out_words.size(); j++) begin
            key_rd.rd   = 1'b1;
            key_rd.addr = j[2:0];
            @(negedge clk);
            check_word($sformatf("k_out[%0d]", j), k_out, out_words[j]);
         end
         key_rd.rd = 1'b0;
      end
      report_test($sformatf("line %0d", t), err_start);
   endtask

   initial begin
      int i;
      rst        = 1'b1;
      e_in       = '0;
      e_in_valid = 1'b0;
      key_rd     = '0;
      for (i = 0; i < 48; i++)
         tdata[i] = 32'hdead_0000 | i;
      $readmemh("sim/encap_testdata.txt", tdata);
      assert (tdata[47] !== (32'hdead_0000 | 47)) else begin
         $display("test data file is missing or short");
         errors++;
      end
      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_reset();
      for (i = 0; i < 8 && !timed_out; i++)
         run_test(i);
      $display("%0d tests run, %0d passed, %0d failed, %0d checker failures",
               n_run, n_pass, n_run - n_pass, u_dut.u_checker.fail_cnt);
      if (errors == 0 && !timed_out && u_dut.u_checker.fail_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== sim/encap_testdata.txt ====
// one run per line, error words low word first
// e0       e1       e2       e3       key_seed c0
00000000 00000000 00000000 00000000 00000001 00000000
00010000 00000000 00000000 00000000 00000001 00010000
00000000 00000001 00000000 00000000 00000001 00042021
00000000 00000004 00000000 00000000 00000001 9dcca8c5
a5a5a5a5 00000007 00000000 00000000 00000001 3c652b40
ffffffff ffffffff ffffffff ffffffff 00000000 ffffffff
12345678 00000002 00000000 00000000 00000001 163c5079
00000000 00000001 00000000 00000000 80000000 80084000

// ==== sources.f ====
rtl/encap_pkg.sv
rtl/stream_slice.sv
rtl/error_store.sv
rtl/syndrome_encoder.sv
rtl/hash_framer.sv
rtl/key_store.sv
rtl/encap_top.sv
sim/encap_checker.sv
sim/encap_tb.sv

// ==== Bender.yml ====
package:
  name: encap

sources:
  - rtl/encap_pkg.sv
  - rtl/stream_slice.sv
  - rtl/error_store.sv
  - rtl/syndrome_encoder.sv
  - rtl/hash_framer.sv
  - rtl/key_store.sv
  - rtl/encap_top.sv
  - target: simulation
    files:
      - sim/encap_checker.sv
      - sim/encap_tb.sv
